//--- verilog/queenPkg.sv
`default_nettype none

package queenPkg;

	////////////////////////////////////////////////////////////
	// board geometry
	////////////////////////////////////////////////////////////

	// rows and columns on the board.
	localparam int BoardSize = 12;

	// row or column index, BoardSize marks an empty slot.
	typedef logic [3:0] coordT;

	// one bit per row or per column.
	typedef logic [BoardSize-1:0] maskT;

	// one bit per diagonal in either direction.
	typedef logic [2*BoardSize-2:0] diagT;

	// stack fill level, 0 up to BoardSize.
	typedef logic [3:0] stackDepthT;

	////////////////////////////////////////////////////////////
	// control encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		sIdle,
		sLoad,
		sSearch,
		sBack,
		sOut
	} solverStateT;

	// command from the FSM to the board and the stack.
	typedef enum logic [2:0] {
		opHold,
		opClear,
		opLoad,
		opPlace,
		opRemove
	} boardOpT;

endpackage

`default_nettype wire

//--- verilog/solverFsm.sv
`default_nettype none

module solverFsm (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             inValid,
	input  wire logic             candFound,
	input  wire logic             colFull,
	input  wire logic             stackEmpty,
	input  wire logic             seqDone,
	output queenPkg::boardOpT     boardOp,
	output logic                  seqStart
);

	queenPkg::solverStateT state;
	queenPkg::solverStateT nextState;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= queenPkg::sIdle;
		end else begin
			state <= nextState;
		end
	end

	////////////////////////////////////////////////////////////
	// next state and board command
	////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		boardOp = queenPkg::opHold;
		seqStart = 1'b0;
		case (state)
			queenPkg::sIdle: begin
				// keep the board empty until presets arrive.
				if (inValid) begin
					boardOp = queenPkg::opLoad;
					nextState = queenPkg::sLoad;
				end else begin
					boardOp = queenPkg::opClear;
				end
			end
			queenPkg::sLoad: begin
				if (inValid) begin
					boardOp = queenPkg::opLoad;
				end else begin
					nextState = queenPkg::sSearch;
				end
			end
			queenPkg::sSearch: begin
				if (colFull) begin
					seqStart = 1'b1;
					nextState = queenPkg::sOut;
				end else if (candFound) begin
					boardOp = queenPkg::opPlace;
				end else begin
					nextState = queenPkg::sBack;
				end
			end
			queenPkg::sBack: begin
				// undo the newest search queen, then retry its column.
				boardOp = queenPkg::opRemove;
				nextState = queenPkg::sSearch;
			end
			queenPkg::sOut: begin
				// board is no longer read on the last beat.
				if (seqDone) begin
					boardOp = queenPkg::opClear;
					nextState = queenPkg::sIdle;
				end
			end
			default: begin
				nextState = queenPkg::sIdle;
			end
		endcase
	end

	// backtracking past the presets means the input had no solution.
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == queenPkg::sBack) |-> !stackEmpty)
		else $error("backtrack with an empty placement stack");

endmodule

`default_nettype wire

//--- verilog/queenBoard.sv
`default_nettype none

module queenBoard (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire queenPkg::boardOpT boardOp,
	input  wire queenPkg::coordT   row,
	input  wire queenPkg::coordT   col,
	input  wire queenPkg::coordT   topRow,
	input  wire queenPkg::coordT   topCol,
	input  wire queenPkg::coordT   outCol,
	output logic                   candFound,
	output logic                   colFull,
	output queenPkg::coordT        candRow,
	output queenPkg::coordT        candCol,
	output queenPkg::coordT        outRow
);

	// grid[r][c] set when a queen sits at row r, column c.
	queenPkg::maskT grid [queenPkg::BoardSize];
	queenPkg::coordT lowBound;

	queenPkg::maskT rowAtk;
	queenPkg::maskT colAtk;
	queenPkg::diagT riseAtk;
	queenPkg::diagT fallAtk;
	queenPkg::maskT freeRows;

	////////////////////////////////////////////////////////////
	// occupancy grid and lower row bound
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grid <= '{default: '0};
			lowBound <= '0;
		end else begin
			case (boardOp)
				queenPkg::opClear: begin
					grid <= '{default: '0};
					lowBound <= '0;
				end
				queenPkg::opLoad: begin
					grid[row][col] <= 1'b1;
				end
				queenPkg::opPlace: begin
					grid[candRow][candCol] <= 1'b1;
					lowBound <= '0;
				end
				queenPkg::opRemove: begin
					// resume one row below the removed queen.
					grid[topRow][topCol] <= 1'b0;
					lowBound <= topRow + queenPkg::coordT'(1);
				end
				default: begin
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// attack maps
	////////////////////////////////////////////////////////////

	always_comb begin
		rowAtk = '0;
		colAtk = '0;
		riseAtk = '0;
		fallAtk = '0;
		for (int r = 0; r < queenPkg::BoardSize; r++) begin
			for (int c = 0; c < queenPkg::BoardSize; c++) begin
				if (grid[r][c]) begin
					rowAtk[r] = 1'b1;
					colAtk[c] = 1'b1;
					riseAtk[r + c] = 1'b1;
					fallAtk[r - c + queenPkg::BoardSize - 1] = 1'b1;
				end
			end
		end
	end

	assign colFull = &colAtk;

	// leftmost empty column, 0 when the board is full.
	always_comb begin
		candCol = '0;
		for (int c = queenPkg::BoardSize - 1; c >= 0; c--) begin
			if (!colAtk[c]) begin
				candCol = queenPkg::coordT'(c);
			end
		end
	end

	// safe rows of that column, at or above the bound.
	always_comb begin
		for (int r = 0; r < queenPkg::BoardSize; r++) begin
			freeRows[r] = !rowAtk[r] && !riseAtk[r + candCol]
				&& !fallAtk[r + queenPkg::BoardSize - 1 - candCol]
				&& (r >= lowBound);
		end
	end

	// lowest free row wins.
	always_comb begin
		candRow = queenPkg::coordT'(queenPkg::BoardSize);
		for (int r = queenPkg::BoardSize - 1; r >= 0; r--) begin
			if (freeRows[r]) begin
				candRow = queenPkg::coordT'(r);
			end
		end
	end

	assign candFound = |freeRows;

	// row of the queen in the column being streamed out.
	always_comb begin
		outRow = '0;
		for (int r = 0; r < queenPkg::BoardSize; r++) begin
			if (grid[r][outCol]) begin
				outRow = queenPkg::coordT'(r);
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(boardOp == queenPkg::opPlace) |-> candFound)
		else $error("place issued without a safe square");

endmodule

`default_nettype wire

//--- verilog/placementStack.sv
`default_nettype none

module placementStack (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire queenPkg::boardOpT boardOp,
	input  wire queenPkg::coordT   candRow,
	input  wire queenPkg::coordT   candCol,
	output queenPkg::coordT        topRow,
	output queenPkg::coordT        topCol,
	output logic                   stackEmpty
);

	queenPkg::coordT stackRow [queenPkg::BoardSize];
	queenPkg::coordT stackCol [queenPkg::BoardSize];
	queenPkg::stackDepthT level;
	queenPkg::stackDepthT topIdx;

	// fill level.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level <= '0;
		end else begin
			case (boardOp)
				queenPkg::opClear:  level <= '0;
				queenPkg::opPlace:  level <= level + queenPkg::stackDepthT'(1);
				queenPkg::opRemove: level <= topIdx;
				default: begin
				end
			endcase
		end
	end

	// entries only, stale slots above the level are ignored.
	always_ff @(posedge clk) begin
		if (boardOp == queenPkg::opPlace) begin
			stackRow[level] <= candRow;
			stackCol[level] <= candCol;
		end
	end

	assign stackEmpty = (level == '0);
	assign topIdx = level - queenPkg::stackDepthT'(1);

	assign topRow = stackEmpty ? queenPkg::coordT'(queenPkg::BoardSize) : stackRow[topIdx];
	assign topCol = stackEmpty ? queenPkg::coordT'(queenPkg::BoardSize) : stackCol[topIdx];

	assert property (@(posedge clk) disable iff (!rst_n)
		(boardOp == queenPkg::opPlace) |-> (level != queenPkg::stackDepthT'(queenPkg::BoardSize)))
		else $error("push onto a full placement stack");

	assert property (@(posedge clk) disable iff (!rst_n)
		(boardOp == queenPkg::opRemove) |-> !stackEmpty)
		else $error("pop from an empty placement stack");

endmodule

`default_nettype wire

//--- verilog/resultSequencer.sv
`default_nettype none

module resultSequencer (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            seqStart,
	input  wire queenPkg::coordT outRow,
	output queenPkg::coordT      outCol,
	output logic                 outValid,
	output queenPkg::coordT      out,
	output logic                 seqDone
);

	logic busy;
	logic beat;
	logic lastCol;

	// a beat is taken in the start cycle and while busy.
	assign beat = seqStart | busy;
	assign lastCol = (outCol == queenPkg::coordT'(queenPkg::BoardSize - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			outCol <= '0;
			outValid <= 1'b0;
			out <= '0;
			seqDone <= 1'b0;
		end else begin
			busy <= beat && !lastCol;
			outValid <= beat;
			seqDone <= beat && lastCol;
			// out stays 0 between results.
			if (beat) begin
				out <= outRow;
			end else begin
				out <= '0;
			end
			if (beat && !lastCol) begin
				outCol <= outCol + queenPkg::coordT'(1);
			end else begin
				outCol <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/queenSolver.sv
`default_nettype none

module queenSolver (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            inValid,
	input  wire queenPkg::coordT row,
	input  wire queenPkg::coordT col,
	output logic                 outValid,
	output queenPkg::coordT      out
);

	queenPkg::boardOpT boardOp;
	logic seqStart;
	logic seqDone;
	logic candFound;
	logic colFull;
	logic stackEmpty;
	queenPkg::coordT candRow;
	queenPkg::coordT candCol;
	queenPkg::coordT topRow;
	queenPkg::coordT topCol;
	queenPkg::coordT outRow;
	queenPkg::coordT outCol;

	solverFsm uFsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.inValid    (inValid),
		.candFound  (candFound),
		.colFull    (colFull),
		.stackEmpty (stackEmpty),
		.seqDone    (seqDone),
		.boardOp    (boardOp),
		.seqStart   (seqStart)
	);

	queenBoard uBoard (
		.clk       (clk),
		.rst_n     (rst_n),
		.boardOp   (boardOp),
		.row       (row),
		.col       (col),
		.topRow    (topRow),
		.topCol    (topCol),
		.outCol    (outCol),
		.candFound (candFound),
		.colFull   (colFull),
		.candRow   (candRow),
		.candCol   (candCol),
		.outRow    (outRow)
	);

	// search queens only, presets never enter the stack.
	placementStack uStack (
		.clk        (clk),
		.rst_n      (rst_n),
		.boardOp    (boardOp),
		.candRow    (candRow),
		.candCol    (candCol),
		.topRow     (topRow),
		.topCol     (topCol),
		.stackEmpty (stackEmpty)
	);

	resultSequencer uSeq (
		.clk      (clk),
		.rst_n    (rst_n),
		.seqStart (seqStart),
		.outRow   (outRow),
		.outCol   (outCol),
		.outValid (outValid),
		.out      (out),
		.seqDone  (seqDone)
	);

endmodule

`default_nettype wire

//--- sim/queenChecker.sv
`default_nettype none

module queenChecker (
	input  wire logic            clk,
	input  wire logic            rst_n,
	input  wire logic            outValid,
	input  wire queenPkg::coordT out,
	input  wire logic [47:0]     expRows,
	input  wire logic [47:0]     presetRows,
	input  wire logic [11:0]     presetMask,
	input  wire logic [127:0]    caseName,
	input  wire logic [31:0]     caseCount,
	output int                   mismatchCount,
	output int                   ruleCount,
	output int                   resultCount
);
	timeunit 1ns;
	timeprecision 1ps;

	queenPkg::coordT beats [12];
	int beatIdx;

	// no shared row or diagonal among the captured beats.
	task automatic checkLegal();
		int dr;
		for (int i = 0; i < 12; i++) begin
			if (beats[i] >= 4'd12) begin
				$display("%0s: column %0d has row %0d, off the board", caseName, i, beats[i]);
				ruleCount++;
			end
			for (int j = i + 1; j < 12; j++) begin
				dr = int'(beats[i]) - int'(beats[j]);
				if (dr == 0) begin
					$display("%0s: columns %0d and %0d share row %0d", caseName, i, j, beats[i]);
					ruleCount++;
				end else if (dr == j - i || dr == i - j) begin
					$display("%0s: columns %0d and %0d share a diagonal", caseName, i, j);
					ruleCount++;
				end
			end
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beatIdx = 0;
			mismatchCount = 0;
			ruleCount = 0;
			resultCount = 0;
		end else if (outValid) begin
			if (beatIdx >= 12) begin
				$display("%0s: outValid stayed high after 12 beats", caseName);
				ruleCount++;
			end else if (resultCount >= int'(caseCount)) begin
				$display("output beat %0d while no case was pending", beatIdx);
				ruleCount++;
			end else begin
				if (out !== expRows[4*beatIdx +: 4]) begin
					$display("MISMATCH %0s column %0d: expected %0d, actual %0d",
						caseName, beatIdx, expRows[4*beatIdx +: 4], out);
					mismatchCount++;
				end
				// preset queens must come back where they were loaded.
				if (presetMask[beatIdx] && out !== presetRows[4*beatIdx +: 4]) begin
					$display("MISMATCH %0s preset column %0d: expected %0d, actual %0d",
						caseName, beatIdx, presetRows[4*beatIdx +: 4], out);
					mismatchCount++;
				end
				beats[beatIdx] = out;
				beatIdx++;
				if (beatIdx == 12) begin
					checkLegal();
					resultCount++;
				end
			end
		end else begin
			if (beatIdx != 0 && beatIdx != 12) begin
				$display("%0s: outValid fell after only %0d beats", caseName, beatIdx);
				ruleCount++;
			end
			beatIdx = 0;
			if (out !== 4'd0) begin
				$display("out is %0d while outValid is low", out);
				ruleCount++;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/queenSolverTb.sv
`default_nettype none

module queenSolverTb;
	timeunit 1ns;
	timeprecision 1ps;

	// cycles allowed for one search, and for a burst to end.
	localparam int SearchTimeout = 200000;
	localparam int BeatTimeout = 20;

	typedef string tokenQueue[$];

	logic clk = 1'b0;
	logic rst_n;
	logic inValid;
	queenPkg::coordT row;
	queenPkg::coordT col;
	logic outValid;
	queenPkg::coordT out;

	logic [47:0] expRows;
	logic [47:0] presetRows;
	logic [11:0] presetMask;
	logic [127:0] caseName;
	int caseCount;
	int mismatchCount;
	int ruleCount;
	int resultCount;
	int runErrCount;
	bit stopRun;
	logic [31:0] lfsr;

	always #4 clk = ~clk;

	queenSolver DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.inValid  (inValid),
		.row      (row),
		.col      (col),
		.outValid (outValid),
		.out      (out)
	);

	queenChecker uChecker (
		.clk           (clk),
		.rst_n         (rst_n),
		.outValid      (outValid),
		.out           (out),
		.expRows       (expRows),
		.presetRows    (presetRows),
		.presetMask    (presetMask),
		.caseName      (caseName),
		.caseCount     (caseCount),
		.mismatchCount (mismatchCount),
		.ruleCount     (ruleCount),
		.resultCount   (resultCount)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic tokenQueue splitTokens(input string line);
		tokenQueue toks;
		int start;
		byte ch;
		start = 0;
		for (int i = 0; i <= line.len(); i++) begin
			ch = (i < line.len()) ? line.getc(i) : 8'h20;
			if (ch == " " || ch == "\t" || ch == "\n" || ch == "\r") begin
				if (i > start) begin
					toks.push_back(line.substr(start, i - 1));
				end
				start = i + 1;
			end
		end
		return toks;
	endfunction

	function automatic logic [127:0] packName(input string s);
		logic [127:0] v;
		v = '0;
		for (int i = 0; i < s.len() && i < 16; i++) begin
			v = {v[119:0], s.getc(i)};
		end
		return v;
	endfunction

	// 0 to 7 idle cycles, three lfsr bits.
	task automatic idleGap();
		int gap;
		gap = 0;
		for (int b = 0; b < 3; b++) begin
			lfsr = nextLfsr(lfsr);
			gap = (gap << 1) | int'(lfsr[0]);
		end
		repeat (gap) @(posedge clk);
	endtask

	task automatic runCase(input tokenQueue toks, input int nPre);
		logic [47:0] exp;
		logic [47:0] pre;
		logic [11:0] mask;
		int base;
		int c;
		int waited;
		exp = '0;
		pre = '0;
		mask = '0;
		base = 2 + 2 * nPre;
		for (int i = 0; i < 12; i++) begin
			exp[4*i +: 4] = 4'(toks[base + i].atoi());
		end
		for (int k = 0; k < nPre; k++) begin
			c = toks[3 + 2 * k].atoi();
			pre[4*c +: 4] = 4'(toks[2 + 2 * k].atoi());
			mask[c] = 1'b1;
		end
		@(posedge clk);
		expRows <= exp;
		presetRows <= pre;
		presetMask <= mask;
		caseName <= packName(toks[0]);
		caseCount <= caseCount + 1;
		// one preset queen per cycle.
		for (int k = 0; k < nPre; k++) begin
			inValid <= 1'b1;
			row <= 4'(toks[2 + 2 * k].atoi());
			col <= 4'(toks[3 + 2 * k].atoi());
			@(posedge clk);
		end
		inValid <= 1'b0;
		row <= '0;
		col <= '0;
		waited = 0;
		while (outValid !== 1'b1 && waited < SearchTimeout) begin
			@(posedge clk);
			waited++;
		end
		if (outValid !== 1'b1) begin
			$display("timeout: case %0s gave no output in %0d cycles", toks[0], SearchTimeout);
			runErrCount++;
			stopRun = 1'b1;
			return;
		end
		waited = 0;
		while (outValid === 1'b1 && waited < BeatTimeout) begin
			@(posedge clk);
			waited++;
		end
		if (outValid === 1'b1) begin
			$display("timeout: case %0s kept outValid high", toks[0]);
			runErrCount++;
			stopRun = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int fd;
		int code;
		int nPre;
		string line;
		tokenQueue toks;
		rst_n = 1'b0;
		inValid = 1'b0;
		row = '0;
		col = '0;
		expRows = '0;
		presetRows = '0;
		presetMask = '0;
		caseName = '0;
		caseCount = 0;
		runErrCount = 0;
		stopRun = 1'b0;
		lfsr = 32'h717fd610;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		// quiet outputs before the first case.
		repeat (4) @(posedge clk);
		fd = $fopen("sim/queenCases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file sim/queenCases.txt");
			runErrCount++;
		end else begin
			while (!stopRun) begin
				code = $fgets(line, fd);
				if (code == 0) begin
					break;
				end
				toks = splitTokens(line);
				if (toks.size() == 0 || toks[0].getc(0) == "#") begin
					continue;
				end
				nPre = (toks.size() > 1) ? toks[1].atoi() : 0;
				if (toks.size() != 14 + 2 * nPre) begin
					$display("malformed case line: %0s", line);
					runErrCount++;
					continue;
				end
				runCase(toks, nPre);
				idleGap();
			end
			$fclose(fd);
		end
		repeat (2) @(posedge clk);
		if (caseCount == 0) begin
			$display("no cases were run");
			runErrCount++;
		end else if (resultCount != caseCount) begin
			$display("only %0d of %0d cases produced a result", resultCount, caseCount);
			runErrCount++;
		end
		$display("errors: %0d mismatches, %0d rule violations, %0d run failures",
			mismatchCount, ruleCount, runErrCount);
		if (mismatchCount + ruleCount + runErrCount == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/queenCases.txt
# name presetCount, then presetCount pairs of (row col), then the 12 expected rows
# of columns 0 to 11. lines that start with # are skipped.
single00 1 0 0 0 2 4 7 9 11 5 10 1 6 8 3
lastPreset 1 3 11 0 2 4 7 9 11 5 10 1 6 8 3
rightDeep 3 3 11 8 10 6 9 0 2 4 7 9 11 5 10 1 6 8 3
midPresets 4 11 5 5 6 10 7 1 8 0 2 4 7 9 11 5 10 1 6 8 3
fullMirror 12 11 0 9 1 7 2 4 3 2 4 0 5 6 6 1 7 10 8 5 9 3 10 8 11 11 9 7 4 2 0 6 1 10 5 3 8
mirrorMinus1 11 11 0 9 1 7 2 4 3 2 4 0 5 1 7 10 8 5 9 3 10 8 11 11 9 7 4 2 0 6 1 10 5 3 8
reverseMinus2 10 6 2 1 3 10 4 5 5 11 6 9 7 7 8 4 9 2 10 0 11 3 8 6 1 10 5 11 9 7 4 2 0

//--- all.f
verilog/queenPkg.sv
verilog/solverFsm.sv
verilog/queenBoard.sv
verilog/placementStack.sv
verilog/resultSequencer.sv
verilog/queenSolver.sv
sim/queenChecker.sv
sim/queenSolverTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= queenSolverTb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	@result="$$(./$(SIM))"; echo "$$result"; \
	echo "$$result" | grep -q '^Test OK$$'

clean:
	rm -rf $(OBJ_DIR)
